// File: Bender.yml
package:
  name: ranc_grid

sources:
  - hw/ranc_pkg.sv
  - hw/packet_fifo.sv
  - hw/packet_router.sv
  - hw/neuron_block.sv
  - hw/neuron_core.sv
  - hw/output_bus.sv
  - hw/ranc_grid.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/ranc_grid_props.sv
      - tests/ranc_grid_tb.sv

// File: hw/neuron_block.sv
`timescale 1ns/1ps

module neuron_block #(
    parameter int NUM_NEURONS      = 4,
    parameter int THRESHOLD        = 2,
    parameter int CORE_INDEX       = 0,
    parameter int GRID_DIMENSION_X = 4
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              tick,
    input  logic              deliver_valid,
    input  ranc_pkg::axon_t   deliver_axon,
    input  logic              spike_ren,
    output ranc_pkg::packet_t spike_packet,
    output logic              spike_empty,
    output logic              token_controller_error
);
    localparam int IDX_WIDTH = (NUM_NEURONS > 1) ? $clog2(NUM_NEURONS) : 1;
    localparam int AXON_BASE = CORE_INDEX * NUM_NEURONS;
    localparam ranc_pkg::dx_t HOPS_TO_OUTPUT = ranc_pkg::dx_t'(GRID_DIMENSION_X - 1 - CORE_INDEX);

    ranc_pkg::emit_state_t state;
    ranc_pkg::potential_t  potentials [NUM_NEURONS];
    logic [NUM_NEURONS-1:0] above;
    logic [NUM_NEURONS-1:0] hit;
    logic [NUM_NEURONS-1:0] fire_mask;
    logic [NUM_NEURONS-1:0] rest_mask;
    logic [IDX_WIDTH-1:0]   spike_idx;
    logic [IDX_WIDTH-1:0]   next_idx;
    logic                   tick_accept;

    assign tick_accept = tick && (state == ranc_pkg::IDLE);

    always_comb begin
        for (int n = 0; n < NUM_NEURONS; n++) begin
            above[n] = (potentials[n] >= ranc_pkg::potential_t'(THRESHOLD));
            hit[n]   = deliver_valid && (deliver_axon == n);
        end
    end

    // Fired neurons restart from zero, plus a spike landing in the same cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int n = 0; n < NUM_NEURONS; n++) begin
                potentials[n] <= '0;
            end
        end else begin
            for (int n = 0; n < NUM_NEURONS; n++) begin
                if (tick_accept && above[n]) begin
                    potentials[n] <= ranc_pkg::potential_t'(hit[n]);
                end else if (hit[n] && (potentials[n] != '1)) begin
                    potentials[n] <= potentials[n] + 1'b1;   // Saturating add
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Spike emission
    //////////////////////////////////////////////////

    always_comb begin
        rest_mask = fire_mask;
        if (state == ranc_pkg::SEND) begin
            rest_mask[spike_idx] = 1'b0;                     // Current spike taken
        end
        next_idx = '0;
        for (int n = NUM_NEURONS - 1; n >= 0; n--) begin
            if (rest_mask[n]) begin
                next_idx = IDX_WIDTH'(n);                    // Lowest pending neuron
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state                  <= ranc_pkg::IDLE;
            fire_mask              <= '0;
            spike_idx              <= '0;
            token_controller_error <= 1'b0;
        end else begin
            if (tick && (state != ranc_pkg::IDLE)) begin
                token_controller_error <= 1'b1;              // Sticky
            end
            case (state)
                ranc_pkg::IDLE: begin
                    if (tick) begin
                        fire_mask <= above;
                        state     <= ranc_pkg::SCAN;
                    end
                end
                ranc_pkg::SCAN: begin
                    if (fire_mask == '0) begin
                        state <= ranc_pkg::IDLE;
                    end else begin
                        spike_idx <= next_idx;
                        state     <= ranc_pkg::SEND;
                    end
                end
                ranc_pkg::SEND: begin
                    if (spike_ren) begin
                        fire_mask <= rest_mask;
                        spike_idx <= next_idx;
                        if (rest_mask == '0) begin
                            state <= ranc_pkg::IDLE;
                        end
                    end
                end
                default: state <= ranc_pkg::IDLE;
            endcase
        end
    end

    assign spike_empty  = (state != ranc_pkg::SEND);
    assign spike_packet = ranc_pkg::make_packet(HOPS_TO_OUTPUT,
                                                ranc_pkg::axon_t'(AXON_BASE + spike_idx));

endmodule

// File: hw/neuron_core.sv
`timescale 1ns/1ps

module neuron_core #(
    parameter int GRID_DIMENSION_X    = 4,
    parameter int NUM_NEURONS         = 4,
    parameter int THRESHOLD           = 2,
    parameter int ROUTER_BUFFER_DEPTH = 4,
    parameter int CORE_INDEX          = 0
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              tick,
    input  ranc_pkg::packet_t west_in,
    input  logic              empty_in_west,
    input  logic              ren_in_east,
    output logic              ren_out_west,
    output ranc_pkg::packet_t east_out,
    output logic              empty_out_east,
    output logic              token_controller_error
);
    ranc_pkg::packet_t spike_packet;
    logic              spike_empty;
    logic              spike_ren;
    logic              deliver_valid;
    ranc_pkg::axon_t   deliver_axon;

    packet_router #(
        .ROUTER_BUFFER_DEPTH(ROUTER_BUFFER_DEPTH)
    ) router (
        .clk           (clk),
        .arst_n        (arst_n),
        .west_in       (west_in),
        .empty_in_west (empty_in_west),
        .spike_packet  (spike_packet),       // Local spikes join west traffic here
        .spike_empty   (spike_empty),
        .ren_in_east   (ren_in_east),
        .ren_out_west  (ren_out_west),
        .spike_ren     (spike_ren),
        .deliver_valid (deliver_valid),
        .deliver_axon  (deliver_axon),
        .east_out      (east_out),
        .empty_out_east(empty_out_east)
    );

    neuron_block #(
        .NUM_NEURONS     (NUM_NEURONS),
        .THRESHOLD       (THRESHOLD),
        .CORE_INDEX      (CORE_INDEX),
        .GRID_DIMENSION_X(GRID_DIMENSION_X)
    ) neurons (
        .clk                   (clk),
        .arst_n                (arst_n),
        .tick                  (tick),
        .deliver_valid         (deliver_valid),
        .deliver_axon          (deliver_axon),
        .spike_ren             (spike_ren),
        .spike_packet          (spike_packet),
        .spike_empty           (spike_empty),
        .token_controller_error(token_controller_error)
    );

endmodule

// File: hw/output_bus.sv
`timescale 1ns/1ps

module output_bus (
    input  logic              clk,
    input  logic              arst_n,
    input  ranc_pkg::packet_t west_in,
    input  logic              empty_in_west,
    output logic              ren_out_west,
    output ranc_pkg::axon_t   packet_out,
    output logic              packet_out_valid
);

    //////////////////////////////////////////////////
    // Terminal tile, drains its west link
    //////////////////////////////////////////////////

    // Always ready, so the grid never stalls on the output side
    assign ren_out_west = !empty_in_west;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            packet_out_valid <= 1'b0;
        end else begin
            packet_out_valid <= ren_out_west;        // One cycle per word read
        end
    end

    // Hop count is spent by now, only the index leaves the grid
    always_ff @(posedge clk) begin
        if (ren_out_west) begin
            packet_out <= ranc_pkg::packet_axon(west_in);
        end
    end

endmodule

// File: hw/packet_fifo.sv
`timescale 1ns/1ps

module packet_fifo #(
    parameter int ROUTER_BUFFER_DEPTH = 4
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              push,
    input  ranc_pkg::packet_t push_data,
    input  logic              ren,
    output ranc_pkg::packet_t data,
    output logic              empty,
    output logic              full
);
    localparam int PTR_WIDTH = (ROUTER_BUFFER_DEPTH > 1) ? $clog2(ROUTER_BUFFER_DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(ROUTER_BUFFER_DEPTH + 1);
    localparam logic [PTR_WIDTH-1:0] LAST_SLOT = PTR_WIDTH'(ROUTER_BUFFER_DEPTH - 1);

    ranc_pkg::packet_t    mem [ROUTER_BUFFER_DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] count;
    logic                 do_push;
    logic                 do_pop;

    assign empty   = (count == '0);
    assign full    = (count == CNT_WIDTH'(ROUTER_BUFFER_DEPTH));
    assign data    = mem[rd_ptr];              // Head entry, first word fall through
    assign do_push = push && !full;
    assign do_pop  = ren && !empty;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

// File: hw/packet_router.sv
`timescale 1ns/1ps

module packet_router #(
    parameter int ROUTER_BUFFER_DEPTH = 4
) (
    input  logic              clk,
    input  logic              arst_n,
    input  ranc_pkg::packet_t west_in,
    input  logic              empty_in_west,
    input  ranc_pkg::packet_t spike_packet,
    input  logic              spike_empty,
    input  logic              ren_in_east,
    output logic              ren_out_west,
    output logic              spike_ren,
    output logic              deliver_valid,
    output ranc_pkg::axon_t   deliver_axon,
    output ranc_pkg::packet_t east_out,
    output logic              empty_out_east
);
    logic              fifo_full;
    logic              pick_west;
    logic              last_west;
    logic              stage_valid;
    logic              stage_local;
    logic              push_east;
    ranc_pkg::packet_t stage_packet;
    ranc_pkg::dx_t     stage_dx;
    ranc_pkg::packet_t hop_packet;

    //////////////////////////////////////////////////
    // Input arbitration
    //////////////////////////////////////////////////

    // West wins a tie unless it won the last one, so a spike waits one slot at most
    assign pick_west    = !empty_in_west && (spike_empty || !last_west);
    assign ren_out_west = !fifo_full && pick_west;
    assign spike_ren    = !fifo_full && !pick_west && !spike_empty;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage_valid <= 1'b0;
            last_west   <= 1'b0;
        end else if (!fifo_full) begin
            stage_valid <= ren_out_west || spike_ren;
            if (ren_out_west || spike_ren) begin
                last_west <= ren_out_west;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ren_out_west) begin
            stage_packet <= west_in;
        end else if (spike_ren) begin
            stage_packet <= spike_packet;
        end
    end

    //////////////////////////////////////////////////
    // Split by hop count
    //////////////////////////////////////////////////

    assign stage_dx      = ranc_pkg::packet_dx(stage_packet);
    assign stage_local   = (stage_dx == '0);                 // Arrived at its tile
    assign deliver_axon  = ranc_pkg::packet_axon(stage_packet);
    assign deliver_valid = stage_valid && stage_local && !fifo_full;
    assign push_east     = stage_valid && !stage_local && !fifo_full;
    assign hop_packet    = ranc_pkg::make_packet(stage_dx - ranc_pkg::dx_t'(1), deliver_axon);

    packet_fifo #(
        .ROUTER_BUFFER_DEPTH(ROUTER_BUFFER_DEPTH)
    ) east_fifo (
        .clk      (clk),
        .arst_n   (arst_n),
        .push     (push_east),
        .push_data(hop_packet),
        .ren      (ren_in_east),
        .data     (east_out),
        .empty    (empty_out_east),
        .full     (fifo_full)
    );

endmodule

// File: hw/ranc_grid.sv
`timescale 1ns/1ps

module ranc_grid #(
    parameter int GRID_DIMENSION_X    = 4,
    parameter int NUM_NEURONS         = 4,
    parameter int THRESHOLD           = 2,
    parameter int ROUTER_BUFFER_DEPTH = 4
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              tick,
    input  logic              input_buffer_empty,
    input  ranc_pkg::packet_t packet_in,
    output ranc_pkg::axon_t   packet_out,
    output logic              packet_out_valid,
    output logic              ren_to_input_buffer,
    output logic              token_controller_error
);
    localparam int NUM_CORES = GRID_DIMENSION_X - 1;     // Last tile is the output bus

    // Link k enters tile k from the west
    wire ranc_pkg::packet_t       link_packets [GRID_DIMENSION_X];
    wire [GRID_DIMENSION_X-1:0]   link_empty;
    wire [GRID_DIMENSION_X-1:0]   link_ren;
    wire [NUM_CORES-1:0]          token_controller_errors;

    assign link_packets[0]        = packet_in;
    assign link_empty[0]          = input_buffer_empty;
    assign ren_to_input_buffer    = link_ren[0];
    assign token_controller_error = |token_controller_errors;

    for (genvar curr_core = 0; curr_core < NUM_CORES; curr_core++) begin : gen_core
        neuron_core #(
            .GRID_DIMENSION_X   (GRID_DIMENSION_X),
            .NUM_NEURONS        (NUM_NEURONS),
            .THRESHOLD          (THRESHOLD),
            .ROUTER_BUFFER_DEPTH(ROUTER_BUFFER_DEPTH),
            .CORE_INDEX         (curr_core)
        ) core (
            .clk                   (clk),
            .arst_n                (arst_n),
            .tick                  (tick),
            .west_in               (link_packets[curr_core]),
            .empty_in_west         (link_empty[curr_core]),
            .ren_in_east           (link_ren[curr_core + 1]),
            .ren_out_west          (link_ren[curr_core]),
            .east_out              (link_packets[curr_core + 1]),
            .empty_out_east        (link_empty[curr_core + 1]),
            .token_controller_error(token_controller_errors[curr_core])
        );
    end

    output_bus out_tile (
        .clk             (clk),
        .arst_n          (arst_n),
        .west_in         (link_packets[NUM_CORES]),
        .empty_in_west   (link_empty[NUM_CORES]),
        .ren_out_west    (link_ren[NUM_CORES]),
        .packet_out      (packet_out),
        .packet_out_valid(packet_out_valid)
    );

endmodule

// File: hw/ranc_pkg.sv
package ranc_pkg;

    //////////////////////////////////////////////////
    // Packet fields
    //////////////////////////////////////////////////

    localparam int DX_WIDTH        = 3;                      // Hops left to travel east
    localparam int AXON_WIDTH      = 4;                      // Axon or global output index
    localparam int PACKET_WIDTH    = DX_WIDTH + AXON_WIDTH;
    localparam int POTENTIAL_WIDTH = 8;

    typedef logic [DX_WIDTH-1:0]        dx_t;
    typedef logic [AXON_WIDTH-1:0]      axon_t;
    typedef logic [PACKET_WIDTH-1:0]    packet_t;            // {dx, axon}
    typedef logic [POTENTIAL_WIDTH-1:0] potential_t;         // Saturates at all ones

    // Neuron block emission
    typedef enum logic [1:0] {
        IDLE,
        SCAN,
        SEND
    } emit_state_t;

    //////////////////////////////////////////////////
    // Field access
    //////////////////////////////////////////////////

    function automatic dx_t packet_dx(input packet_t packet);
        return packet[PACKET_WIDTH-1 -: DX_WIDTH];
    endfunction

    function automatic axon_t packet_axon(input packet_t packet);
        return packet[AXON_WIDTH-1:0];
    endfunction

    function automatic packet_t make_packet(input dx_t dx, input axon_t axon);
        return {dx, axon};
    endfunction

endpackage

// File: ranc_grid.f
hw/ranc_pkg.sv
hw/packet_fifo.sv
hw/packet_router.sv
hw/neuron_block.sv
hw/neuron_core.sv
hw/output_bus.sv
hw/ranc_grid.sv
tests/tb_clock_gen.sv
tests/ranc_grid_props.sv
tests/ranc_grid_tb.sv

// File: tests/ranc_grid_props.sv
`timescale 1ns/1ps

module ranc_grid_props (
    input logic            clk,
    input logic            arst_n,
    input logic            input_buffer_empty,
    input logic            ren_to_input_buffer,
    input logic            packet_out_valid,
    input ranc_pkg::axon_t packet_out,
    input logic            token_controller_error
);
    // Never pull a word from an empty input buffer
    no_read_when_empty: assert property (@(posedge clk) disable iff (!arst_n)
        !(ren_to_input_buffer && input_buffer_empty))
        else $error("Input buffer read while it was empty");

    // A valid output always carries a defined index
    valid_index_known: assert property (@(posedge clk) disable iff (!arst_n)
        packet_out_valid |-> !$isunknown(packet_out))
        else $error("packet_out is unknown while packet_out_valid is high");

    error_is_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        !$fell(token_controller_error))
        else $error("token_controller_error fell without a reset");

endmodule

bind ranc_grid ranc_grid_props props (
    .clk                   (clk),
    .arst_n                (arst_n),
    .input_buffer_empty    (input_buffer_empty),
    .ren_to_input_buffer   (ren_to_input_buffer),
    .packet_out_valid      (packet_out_valid),
    .packet_out            (packet_out),
    .token_controller_error(token_controller_error)
);

// File: tests/ranc_grid_tb.sv
`timescale 1ns/1ps

module ranc_grid_tb;
    localparam int GRID_DIMENSION_X = 4;
    localparam int NUM_NEURONS      = 4;
    localparam int THRESHOLD        = 2;
    localparam int NUM_CORES        = GRID_DIMENSION_X - 1;
    localparam int ROW_WAIT         = 4 * GRID_DIMENSION_X;
    localparam int TABLE_LEN        = 16;

    typedef struct {
        string name;
        int    core;                             // GRID_DIMENSION_X - 1 is the output tile
        int    axon;
        int    count;                            // Negative draws core, axon and count
        int    tick;                             // 0 none, 1 tick, 2 ticks back to back
    } row_t;

    logic              clk;
    logic              arst_n;
    logic              tick;
    logic              input_buffer_empty;
    ranc_pkg::packet_t packet_in;
    ranc_pkg::axon_t   packet_out;
    logic              packet_out_valid;
    logic              ren_to_input_buffer;
    logic              token_controller_error;

    row_t              rows[$];
    ranc_pkg::packet_t input_q[$];               // External input buffer
    ranc_pkg::axon_t   expected_q[$];            // Indices still owed by the grid
    int                potentials [NUM_CORES*NUM_NEURONS];
    integer            seed = 32'h8f5aa39e;
    string             test_name = "reset";
    logic              error_expected = 1'b0;

    tb_clock_gen clock_gen (.clk(clk), .arst_n(arst_n));

    ranc_grid #(
        .GRID_DIMENSION_X   (GRID_DIMENSION_X),
        .NUM_NEURONS        (NUM_NEURONS),
        .THRESHOLD          (THRESHOLD),
        .ROUTER_BUFFER_DEPTH(4)
    ) DUT (
        .clk                   (clk),
        .arst_n                (arst_n),
        .tick                  (tick),
        .input_buffer_empty    (input_buffer_empty),
        .packet_in             (packet_in),
        .packet_out            (packet_out),
        .packet_out_valid      (packet_out_valid),
        .ren_to_input_buffer   (ren_to_input_buffer),
        .token_controller_error(token_controller_error)
    );

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_axon(input string name, input ranc_pkg::axon_t expected,
                              input ranc_pkg::axon_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("FAILED %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            fail_run($sformatf("FAILED %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    task automatic score_output();
        int hit;
        hit = -1;
        foreach (expected_q[i]) begin
            if (hit < 0 && expected_q[i] == packet_out) hit = i;
        end
        if (hit >= 0) begin
            expected_q.delete(hit);
        end else if (expected_q.size() > 0) begin
            check_axon(test_name, expected_q[0], packet_out);
        end else begin
            fail_run($sformatf("Output index %0d appeared in test %s with none expected",
                               packet_out, test_name));
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    // One clock: input buffer pops on the read seen at the rising edge
    task automatic step();
        logic taken;
        @(posedge clk);
        taken = ren_to_input_buffer;
        @(negedge clk);
        if (taken && input_q.size() > 0) void'(input_q.pop_front());
        input_buffer_empty = (input_q.size() == 0);
        packet_in          = (input_q.size() > 0) ? input_q[0] : '0;
        if (packet_out_valid) score_output();
    endtask

    task automatic fire_model();
        for (int i = 0; i < NUM_CORES * NUM_NEURONS; i++) begin
            if (potentials[i] >= THRESHOLD) begin
                expected_q.push_back(ranc_pkg::axon_t'(i));
                potentials[i] = 0;
            end
        end
    endtask

    task automatic add_row(input string name, input int core, input int axon,
                           input int count, input int tick_kind);
        row_t r;
        r.name  = name;
        r.core  = core;
        r.axon  = axon;
        r.count = count;
        r.tick  = tick_kind;
        rows.push_back(r);
    endtask

    task automatic apply_row(input row_t r);
        int core;
        int axon;
        int count;
        core      = r.core;
        axon      = r.axon;
        count     = r.count;
        test_name = r.name;
        if (count < 0) begin
            core  = $unsigned($random(seed)) % NUM_CORES;
            axon  = $unsigned($random(seed)) % NUM_NEURONS;
            count = $unsigned($random(seed)) % 4;
        end
        for (int k = 0; k < count; k++) begin
            input_q.push_back({ranc_pkg::dx_t'(core), ranc_pkg::axon_t'(axon)});
            if (core < NUM_CORES) potentials[core*NUM_NEURONS + axon]++;
            else expected_q.push_back(ranc_pkg::axon_t'(axon));   // Passes straight through
        end
        while (input_q.size() != 0) step();
        repeat (ROW_WAIT) step();
        if (r.tick > 0) begin
            tick = 1'b1;
            repeat (r.tick) step();
            tick = 1'b0;
            fire_model();                        // A second tick is refused by the FSM
            if (r.tick > 1) error_expected = 1'b1;
        end
        while (expected_q.size() != 0) step();
        repeat (2 * ROW_WAIT) step();            // Room for any stray output
        check_flag(r.name, error_expected, token_controller_error);
    endtask

    initial begin
        tick               = 1'b0;
        input_buffer_empty = 1'b1;
        packet_in          = '0;
        foreach (potentials[i]) potentials[i] = 0;

        add_row("direct_out", GRID_DIMENSION_X - 1, 13, 1, 0);
        add_row("threshold_c1", 1, 2, THRESHOLD, 1);
        add_row("below_c2", 2, 0, 1, 1);
        add_row("accumulate_c2", 2, 0, 1, 1);
        add_row("multi_c0", 0, 1, 2, 0);
        add_row("multi_c1", 1, 3, 3, 0);
        add_row("multi_c2", 2, 2, 2, 1);
        for (int i = 0; i < 4; i++) add_row($sformatf("random_%0d", i), 0, 0, -1, 1);
        for (int n = 0; n < NUM_NEURONS; n++) add_row($sformatf("charge_c0_n%0d", n), 0, n, 2, 0);
        add_row("double_tick", 0, 0, 0, 2);

        @(posedge arst_n);
        check_flag("reset_error", 1'b0, token_controller_error);
        check_flag("reset_valid", 1'b0, packet_out_valid);
        check_flag("reset_ren", 1'b0, ren_to_input_buffer);
        foreach (rows[i]) apply_row(rows[i]);
        $display("sim passed");
        $finish;
    end

    // Watchdog
    initial begin
        repeat (10 + TABLE_LEN * (ROW_WAIT + 100)) @(posedge clk);
        fail_run("Timed out before the stimulus table was finished");
    end

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 10.0,
    parameter int  RESET_CYCLES = 10
) (
    output logic clk,
    output logic arst_n
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;                           // Released away from the active edge
    end

endmodule
